// File: design/mem_map_pkg.sv
`default_nettype none

package mem_map_pkg;

    //////////////////////////////
    // word address layout
    //////////////////////////////

    // cpu word address, byte offset already stripped
    localparam int ADDR_W = 30;

    // region field sits in the top four address bits
    localparam int REGION_LSB = 26;

    //////////////////////////////
    // region codes
    //////////////////////////////

    // any code not listed here falls through to main data memory
    typedef enum logic [3:0] {
        REG_TEXT   = 4'hc,  // character store of the text display
        REG_TIMER  = 4'hd,  // timer stub
        REG_KBD    = 4'he,  // keyboard stub
        REG_LOADER = 4'hf   // loader ram, also an instruction source
    } region_e;

endpackage

`default_nettype wire

// File: design/bus_pkg.sv
`default_nettype none

package bus_pkg;

    //////////////////////////////
    // cpu data port
    //////////////////////////////

    // one enable per byte of a 32-bit word
    localparam int BE_W = 4;

    // request opcode on the data port
    typedef enum logic [1:0] {
        OP_NONE  = 2'd0,  // idle slot, taken but no effect
        OP_READ  = 2'd1,
        OP_WRITE = 2'd2
    } mem_op_e;

endpackage

`default_nettype wire

// File: design/region_decoder.sv
`timescale 1ns/1ns
`default_nettype none

module region_decoder (
    input  wire                              text_mem_clk,
    input  wire                              rst,
    input  wire                              dmem_valid,
    input  wire bus_pkg::mem_op_e            dmem_op,
    input  wire [mem_map_pkg::ADDR_W-1:0]    dmem_addr,
    input  wire                              dr_ready,
    input  wire                              dr_rvalid,
    input  wire [31:0]                       dr_rdata,
    input  wire                              tw_ready,
    input  wire [31:0]                       loader_rdata,
    output logic                             dr_valid,
    output logic                             tw_valid,
    output logic                             ld_en,
    output logic                             ld_we,
    output logic                             dmem_ready,
    output logic [31:0]                      dmem_rdata,
    output logic                             dmem_rvalid
);
    import mem_map_pkg::*;
    import bus_pkg::*;

    region_e region;
    logic    is_read, is_write;
    logic    to_data, to_text, to_loader;
    logic    imm_ok, take;
    logic    dr_pend;    // data read still in flight
    logic    rd_pend;    // immediate read returns next cycle
    logic    rd_loader;  // that read came from the loader

    assign region   = region_e'(dmem_addr[ADDR_W-1:REGION_LSB]);
    assign is_read  = dmem_op == OP_READ;
    assign is_write = dmem_op == OP_WRITE;

    //////////////////////////////
    // target select
    //////////////////////////////

    assign to_text   = (region == REG_TEXT) && is_write;
    assign to_loader = region == REG_LOADER;
    // everything outside c..f is main memory
    assign to_data   = !(region inside {REG_TEXT, REG_TIMER, REG_KBD, REG_LOADER})
                       && (is_read || is_write);

    // immediate reads wait behind an outstanding data read to keep order
    assign imm_ok = !dr_pend || dr_rvalid;

    always_comb begin
        if (to_data) begin
            dmem_ready = dr_ready;
        end else if (to_text) begin
            dmem_ready = tw_ready;
        end else if (is_read) begin
            dmem_ready = imm_ok;
        end else begin
            dmem_ready = 1'b1;
        end
    end

    assign take     = dmem_valid && dmem_ready;
    assign dr_valid = dmem_valid && to_data;
    assign tw_valid = dmem_valid && to_text;
    // cpu owns loader port a only in the cycle its request is taken
    assign ld_en    = take && to_loader;
    assign ld_we    = ld_en && is_write;

    //////////////////////////////
    // return steering
    //////////////////////////////

    always_ff @(posedge text_mem_clk) begin
        if (rst) begin
            dr_pend   <= 1'b0;
            rd_pend   <= 1'b0;
            rd_loader <= 1'b0;
        end else begin
            rd_pend   <= take && is_read && !to_data;
            rd_loader <= to_loader;
            if (take && to_data && is_read) begin
                dr_pend <= 1'b1;
            end else if (dr_rvalid) begin
                dr_pend <= 1'b0;
            end
        end
    end

    // stubs and text reads answer zero
    assign dmem_rvalid = rd_pend || dr_rvalid;
    assign dmem_rdata  = dr_rvalid ? dr_rdata : (rd_loader ? loader_rdata : 32'h0);

endmodule

`default_nettype wire

// File: design/text_write_seq.sv
`timescale 1ns/1ns
`default_nettype none

module text_write_seq #(
    parameter int TEXT_AW = 15
) (
    input  wire                              text_mem_clk,
    input  wire                              rst,
    input  wire                              tw_valid,
    input  wire [mem_map_pkg::ADDR_W-1:0]    dmem_addr,
    input  wire [31:0]                       dmem_wdata,
    input  wire [bus_pkg::BE_W-1:0]          dmem_be,
    output logic                             tw_ready,
    output logic                             text_we,
    output logic [TEXT_AW-1:0]               text_waddr,
    output logic [7:0]                       text_wchar
);

    // idle, two write cycles, then hold ready until the cpu moves on
    typedef enum logic [1:0] {
        TW_IDLE,
        TW_WR1,
        TW_WR2,
        TW_DONE
    } tw_state_e;

    tw_state_e state;
    logic [1:0] lane;

    //////////////////////////////
    // write sequencer
    //////////////////////////////

    always_ff @(posedge text_mem_clk) begin
        if (rst || !tw_valid) begin
            // dropped valid also lands back in idle
            state <= TW_IDLE;
        end else begin
            case (state)
                TW_IDLE: state <= TW_WR1;
                TW_WR1:  state <= TW_WR2;
                TW_WR2:  state <= TW_DONE;
                default: state <= TW_IDLE;  // taken in done
            endcase
        end
    end

    assign tw_ready = state == TW_DONE;
    assign text_we  = tw_valid && ((state == TW_WR1) || (state == TW_WR2));

    //////////////////////////////
    // byte lane pick
    //////////////////////////////

    // be msb is lane 0, same order as the data memory
    always_comb begin
        case (dmem_be)
            4'b1000: begin
                lane       = 2'd0;
                text_wchar = dmem_wdata[7:0];
            end
            4'b0100: begin
                lane       = 2'd1;
                text_wchar = dmem_wdata[15:8];
            end
            4'b0010: begin
                lane       = 2'd2;
                text_wchar = dmem_wdata[23:16];
            end
            default: begin
                // 0001 and any non one-hot pattern
                lane       = 2'd3;
                text_wchar = dmem_wdata[31:24];
            end
        endcase
    end

    // word index low bits then lane
    assign text_waddr = {dmem_addr[TEXT_AW-3:0], lane};

endmodule

`default_nettype wire

// File: design/data_ram.sv
`timescale 1ns/1ns
`default_nettype none

module data_ram #(
    parameter int DATA_LATENCY = 3,
    parameter int DATA_AW      = 10
) (
    input  wire                              text_mem_clk,
    input  wire                              rst,
    input  wire                              dr_valid,
    input  wire bus_pkg::mem_op_e            dmem_op,
    input  wire [mem_map_pkg::ADDR_W-1:0]    dmem_addr,
    input  wire [31:0]                       dmem_wdata,
    input  wire [bus_pkg::BE_W-1:0]          dmem_be,
    input  wire [mem_map_pkg::ADDR_W-1:0]    instr_addr,
    output logic                             dr_ready,
    output logic                             dr_rvalid,
    output logic [31:0]                      dr_rdata,
    output logic [31:0]                      instr_data
);
    import bus_pkg::*;

    localparam int CNT_W = $clog2(DATA_LATENCY + 1);

    typedef enum logic {
        DR_IDLE,
        DR_BUSY
    } dr_state_e;

    logic [31:0] mem [0:2**DATA_AW-1];
    dr_state_e   state;
    logic [CNT_W-1:0] busy_cnt;  // cycles left in busy, 0 is the last
    logic        rd_pend;
    logic        take;
    logic [DATA_AW-1:0] waddr;

    assign dr_ready = state == DR_IDLE;
    assign take     = dr_valid && dr_ready;
    assign waddr    = dmem_addr[DATA_AW-1:0];

    //////////////////////////////
    // busy timer, stands in for the cache stall
    //////////////////////////////

    always_ff @(posedge text_mem_clk) begin
        if (rst) begin
            state    <= DR_IDLE;
            busy_cnt <= '0;
            rd_pend  <= 1'b0;
        end else if (take) begin
            state    <= DR_BUSY;
            busy_cnt <= CNT_W'(DATA_LATENCY - 1);
            rd_pend  <= dmem_op == OP_READ;
        end else if (state == DR_BUSY) begin
            if (busy_cnt == '0) begin
                state <= DR_IDLE;
            end else begin
                busy_cnt <= busy_cnt - 1'b1;
            end
        end
    end

    // pulse in the last busy cycle
    assign dr_rvalid = (state == DR_BUSY) && (busy_cnt == '0) && rd_pend;

    //////////////////////////////
    // storage
    //////////////////////////////

    // read captured at take, memory cannot change while busy
    always_ff @(posedge text_mem_clk) begin
        if (take) begin
            dr_rdata <= mem[waddr];
            if (dmem_op == OP_WRITE) begin
                for (int i = 0; i < BE_W; i++) begin
                    // be msb is lane 0
                    if (dmem_be[BE_W-1-i]) begin
                        mem[waddr][8*i +: 8] <= dmem_wdata[8*i +: 8];
                    end
                end
            end
        end
        instr_data <= mem[instr_addr[DATA_AW-1:0]];
    end

endmodule

`default_nettype wire

// File: design/loader_ram.sv
`timescale 1ns/1ns
`default_nettype none

module loader_ram #(
    parameter int LOADER_AW = 13
) (
    input  wire                  text_mem_clk,
    input  wire [LOADER_AW-1:0]  addr_a,
    input  wire [31:0]           wdata_a,
    input  wire                  we_a,
    input  wire [LOADER_AW-1:0]  addr_b,
    output logic [31:0]          rdata_a,
    output logic [31:0]          rdata_b
);

    logic [31:0] mem [0:2**LOADER_AW-1];

    //////////////////////////////
    // port a, data side
    //////////////////////////////

    // shared by the cpu and the outside loader
    // read returns old word on a write cycle
    always_ff @(posedge text_mem_clk) begin
        if (we_a) begin
            mem[addr_a] <= wdata_a;
        end
        rdata_a <= mem[addr_a];
    end

    //////////////////////////////
    // port b, instruction side
    //////////////////////////////

    // read only
    always_ff @(posedge text_mem_clk) begin
        rdata_b <= mem[addr_b];
    end

endmodule

`default_nettype wire

// File: design/text_ram.sv
`timescale 1ns/1ns
`default_nettype none

module text_ram #(
    parameter int TEXT_AW = 15
) (
    input  wire                text_mem_clk,
    input  wire                text_we,
    input  wire [TEXT_AW-1:0]  text_waddr,
    input  wire [7:0]          text_wchar,
    input  wire [TEXT_AW-1:0]  text_scan_addr,
    output logic [7:0]         text_scan_char
);

    // one character per byte
    logic [7:0] mem [0:2**TEXT_AW-1];

    //////////////////////////////
    // write from sequencer
    //////////////////////////////

    always_ff @(posedge text_mem_clk) begin
        if (text_we) begin
            mem[text_waddr] <= text_wchar;
        end
    end

    // display scan side, one cycle latency
    always_ff @(posedge text_mem_clk) begin
        text_scan_char <= mem[text_scan_addr];
    end

endmodule

`default_nettype wire

// File: design/cpu_mem_interface.sv
`timescale 1ns/1ns
`default_nettype none

module cpu_mem_interface #(
    parameter int DATA_LATENCY = 3,
    parameter int DATA_AW      = 10,
    parameter int LOADER_AW    = 13,
    parameter int TEXT_AW      = 15
) (
    input  wire                              text_mem_clk,
    input  wire                              rst,
    input  wire                              dmem_valid,
    input  wire bus_pkg::mem_op_e            dmem_op,
    input  wire [mem_map_pkg::ADDR_W-1:0]    dmem_addr,
    input  wire [31:0]                       dmem_wdata,
    input  wire [bus_pkg::BE_W-1:0]          dmem_be,
    input  wire [mem_map_pkg::ADDR_W-1:0]    instr_addr,
    input  wire [LOADER_AW-1:0]              loader_addr,
    input  wire [TEXT_AW-1:0]                text_scan_addr,
    output logic                             dmem_ready,
    output logic [31:0]                      dmem_rdata,
    output logic                             dmem_rvalid,
    output logic [31:0]                      instr_rdata,
    output logic [31:0]                      loader_rdata,
    output logic [7:0]                       text_scan_char
);
    import mem_map_pkg::*;

    // decoder to targets
    logic                 dr_valid, dr_ready, dr_rvalid;
    logic [31:0]          dr_rdata;
    logic                 tw_valid, tw_ready;
    logic                 ld_en, ld_we;
    // text write path
    logic                 text_we;
    logic [TEXT_AW-1:0]   text_waddr;
    logic [7:0]           text_wchar;
    // instruction sources
    logic [31:0]          dr_instr, ld_instr;
    logic                 instr_ld_q;
    logic [LOADER_AW-1:0] ld_addr_a;

    region_decoder u_region_decoder (
        .text_mem_clk (text_mem_clk), .rst (rst),
        .dmem_valid   (dmem_valid),   .dmem_op (dmem_op),   .dmem_addr (dmem_addr),
        .dr_ready     (dr_ready),     .dr_rvalid (dr_rvalid), .dr_rdata (dr_rdata),
        .tw_ready     (tw_ready),     .loader_rdata (loader_rdata),
        .dr_valid     (dr_valid),     .tw_valid (tw_valid),
        .ld_en        (ld_en),        .ld_we (ld_we),
        .dmem_ready   (dmem_ready),   .dmem_rdata (dmem_rdata), .dmem_rvalid (dmem_rvalid)
    );

    text_write_seq #(.TEXT_AW(TEXT_AW)) u_text_write_seq (
        .text_mem_clk (text_mem_clk), .rst (rst), .tw_valid (tw_valid),
        .dmem_addr    (dmem_addr),    .dmem_wdata (dmem_wdata), .dmem_be (dmem_be),
        .tw_ready     (tw_ready),     .text_we (text_we),
        .text_waddr   (text_waddr),   .text_wchar (text_wchar)
    );

    data_ram #(.DATA_LATENCY(DATA_LATENCY), .DATA_AW(DATA_AW)) u_data_ram (
        .text_mem_clk (text_mem_clk), .rst (rst),
        .dr_valid     (dr_valid),     .dmem_op (dmem_op),   .dmem_addr (dmem_addr),
        .dmem_wdata   (dmem_wdata),   .dmem_be (dmem_be),   .instr_addr (instr_addr),
        .dr_ready     (dr_ready),     .dr_rvalid (dr_rvalid),
        .dr_rdata     (dr_rdata),     .instr_data (dr_instr)
    );

    //////////////////////////////
    // loader port a ownership
    //////////////////////////////

    // outside loader drives port a unless the cpu request is being taken
    assign ld_addr_a = ld_en ? dmem_addr[LOADER_AW-1:0] : loader_addr;

    loader_ram #(.LOADER_AW(LOADER_AW)) u_loader_ram (
        .text_mem_clk (text_mem_clk),
        .addr_a (ld_addr_a), .wdata_a (dmem_wdata), .we_a (ld_we),
        .addr_b (instr_addr[LOADER_AW-1:0]),
        .rdata_a (loader_rdata), .rdata_b (ld_instr)
    );

    text_ram #(.TEXT_AW(TEXT_AW)) u_text_ram (
        .text_mem_clk (text_mem_clk), .text_we (text_we),
        .text_waddr (text_waddr), .text_wchar (text_wchar),
        .text_scan_addr (text_scan_addr), .text_scan_char (text_scan_char)
    );

    //////////////////////////////
    // instruction fetch redirect
    //////////////////////////////

    // both sources have one cycle latency, so the select is delayed to match
    always_ff @(posedge text_mem_clk) begin
        if (rst) begin
            instr_ld_q <= 1'b0;
        end else begin
            instr_ld_q <= instr_addr[ADDR_W-1:REGION_LSB] == REG_LOADER;
        end
    end

    assign instr_rdata = instr_ld_q ? ld_instr : dr_instr;

endmodule

`default_nettype wire

// File: verification/tb_model.svh
`ifndef TB_MODEL_SVH
`define TB_MODEL_SVH
`default_nettype none

//////////////////////////////
// shadow memories
//////////////////////////////

// only words the tests wrote are read back
logic [31:0] model_data   [0:2**DATA_AW-1];
logic [31:0] model_loader [0:2**LOADER_AW-1];
logic [7:0]  model_text   [0:2**TEXT_AW-1];

// galois lfsr state
logic [15:0] lfsr = 16'd96;

// taps 16 14 13 11, one step per bit taken
function automatic logic [31:0] rand_bits(input int n);
    logic [31:0] v;
    v = '0;
    for (int i = 0; i < n; i++) begin
        v = {v[30:0], lfsr[0]};
        lfsr = lfsr[0] ? ((lfsr >> 1) ^ 16'hb400) : (lfsr >> 1);
    end
    return v;
endfunction

//////////////////////////////
// byte lane rule
//////////////////////////////

// be msb selects byte 0 of the word
function automatic logic [31:0] merge_bytes(input logic [31:0] old_w, input logic [31:0] wdata,
                                            input logic [3:0] be);
    logic [31:0] r;
    r = old_w;
    for (int i = 0; i < 4; i++) begin
        if (be[3-i]) begin
            r[8*i +: 8] = wdata[8*i +: 8];
        end
    end
    return r;
endfunction

// non one-hot patterns land in lane 3
function automatic logic [1:0] text_lane(input logic [3:0] be);
    case (be)
        4'b1000: return 2'd0;
        4'b0100: return 2'd1;
        4'b0010: return 2'd2;
        default: return 2'd3;
    endcase
endfunction

function automatic logic [7:0] text_char(input logic [31:0] wdata, input logic [3:0] be);
    return wdata[8*text_lane(be) +: 8];
endfunction

// expected cpu read word, text and stubs read as zero
function automatic logic [31:0] exp_read(input logic [ADDR_W-1:0] addr);
    case (addr[ADDR_W-1:REGION_LSB])
        REG_LOADER: return model_loader[addr[LOADER_AW-1:0]];
        REG_TEXT, REG_TIMER, REG_KBD: return 32'h0;
        default: return model_data[addr[DATA_AW-1:0]];
    endcase
endfunction

`default_nettype wire
`endif

// File: verification/tb_cpu_mem_interface.sv
`timescale 1ns/1ns
`default_nettype none

module tb_cpu_mem_interface;
    import mem_map_pkg::*;
    import bus_pkg::*;

    localparam int DATA_LATENCY = 3;
    localparam int DATA_AW      = 10;
    localparam int LOADER_AW    = 13;
    localparam int TEXT_AW      = 15;
    // upper bound on bus requests and port reads over all tests
    localparam int NUM_REQ      = 160;
    localparam int WATCHDOG_CYC = NUM_REQ * (DATA_LATENCY + 4) + 200;

    logic                  text_mem_clk;
    logic                  rst;
    logic                  dmem_valid;
    mem_op_e               dmem_op;
    logic [ADDR_W-1:0]     dmem_addr;
    logic [31:0]           dmem_wdata;
    logic [BE_W-1:0]       dmem_be;
    logic [ADDR_W-1:0]     instr_addr;
    logic [LOADER_AW-1:0]  loader_addr;
    logic [TEXT_AW-1:0]    text_scan_addr;
    logic                  dmem_ready;
    logic [31:0]           dmem_rdata;
    logic                  dmem_rvalid;
    logic [31:0]           instr_rdata;
    logic [31:0]           loader_rdata;
    logic [7:0]            text_scan_char;

    `include "tb_model.svh"

    // expected read returns in issue order
    logic [31:0]          exp_q [$];
    logic [DATA_AW-1:0]   data_idx [8];
    logic [LOADER_AW-1:0] ld_idx [8];
    int checks = 0;
    int errors = 0;
    int base_checks = 0;
    int base_errors = 0;

    cpu_mem_interface #(
        .DATA_LATENCY (DATA_LATENCY),
        .DATA_AW      (DATA_AW),
        .LOADER_AW    (LOADER_AW),
        .TEXT_AW      (TEXT_AW)
    ) u_cpu_mem_interface (
        .text_mem_clk (text_mem_clk), .rst (rst),
        .dmem_valid (dmem_valid), .dmem_op (dmem_op), .dmem_addr (dmem_addr),
        .dmem_wdata (dmem_wdata), .dmem_be (dmem_be), .instr_addr (instr_addr),
        .loader_addr (loader_addr), .text_scan_addr (text_scan_addr),
        .dmem_ready (dmem_ready), .dmem_rdata (dmem_rdata), .dmem_rvalid (dmem_rvalid),
        .instr_rdata (instr_rdata), .loader_rdata (loader_rdata),
        .text_scan_char (text_scan_char)
    );

    initial begin
        text_mem_clk = 1'b0;
        forever #20 text_mem_clk = ~text_mem_clk;
    end

    //////////////////////////////
    // helpers
    //////////////////////////////

    task automatic check_value(input string name, input logic [31:0] exp, input logic [31:0] got);
        checks++;
        assert (got === exp) else begin
            $display("MISMATCH time %0t %s expected %h got %h", $time, name, exp, got);
            errors++;
        end
    endtask

    // model update at the edge where the request is taken
    task automatic record_take(input mem_op_e op, input logic [ADDR_W-1:0] addr,
                               input logic [31:0] wdata, input logic [3:0] be);
        if (op == OP_READ) begin
            exp_q.push_back(exp_read(addr));
        end else if (op == OP_WRITE) begin
            case (addr[ADDR_W-1:REGION_LSB])
                REG_TEXT: model_text[{addr[TEXT_AW-3:0], text_lane(be)}] = text_char(wdata, be);
                REG_LOADER: model_loader[addr[LOADER_AW-1:0]] = wdata;
                // stub writes vanish
                REG_TIMER, REG_KBD: begin
                end
                default: model_data[addr[DATA_AW-1:0]] =
                    merge_bytes(model_data[addr[DATA_AW-1:0]], wdata, be);
            endcase
        end
    endtask

    // called at a falling edge, returns at one, valid dropped after the take
    task automatic issue(input mem_op_e op, input logic [ADDR_W-1:0] addr,
                         input logic [31:0] wdata, input logic [3:0] be, output int waited);
        logic rdy;
        waited = 0;
        rdy = 1'b0;
        dmem_valid = 1'b1;
        dmem_op = op;
        dmem_addr = addr;
        dmem_wdata = wdata;
        dmem_be = be;
        while (!rdy) begin
            // ready settles well before the rising edge
            #1;
            rdy = dmem_ready;
            @(posedge text_mem_clk);
            if (!rdy) begin
                waited++;
                @(negedge text_mem_clk);
            end
        end
        record_take(op, addr, wdata, be);
        @(negedge text_mem_clk);
        dmem_valid = 1'b0;
        dmem_op = OP_NONE;
    endtask

    task automatic wait_returns();
        while (exp_q.size() != 0) begin
            @(negedge text_mem_clk);
        end
    endtask

    task automatic report_test(input int num, input string name);
        $display("test %0d %s done with %0d checks and %0d errors", num, name,
                 checks - base_checks, errors - base_errors);
        base_checks = checks;
        base_errors = errors;
    endtask

    //////////////////////////////
    // read return compare
    //////////////////////////////

    // outputs here are all registered, so the falling edge is a safe sample point
    initial begin : compare_returns
        forever begin
            @(negedge text_mem_clk);
            if (!rst && dmem_rvalid) begin
                assert (exp_q.size() != 0) else begin
                    $display("time %0t read data returned with no read outstanding", $time);
                    errors++;
                end
                if (exp_q.size() != 0) begin
                    check_value("dmem_rdata", exp_q.pop_front(), dmem_rdata);
                end
            end
        end
    end

    initial begin : watchdog
        repeat (WATCHDOG_CYC) @(posedge text_mem_clk);
        $display("watchdog expired after %0d cycles, the run did not finish", WATCHDOG_CYC);
        $display("TEST FAIL");
        $finish;
    end

    //////////////////////////////
    // stimulus
    //////////////////////////////

    initial begin : stimulus
        int                   waited;
        logic [ADDR_W-1:0]    a;
        logic [31:0]          d;
        logic [3:0]           be;
        logic [3:0]           stub;
        logic [1:0]           lane;
        logic [TEXT_AW-3:0]   t_widx [8];
        logic [1:0]           t_lane [8];
        rst = 1'b1;
        dmem_valid = 1'b0;
        dmem_op = OP_NONE;
        dmem_addr = '0;
        dmem_wdata = '0;
        dmem_be = '0;
        instr_addr = '0;
        loader_addr = '0;
        text_scan_addr = '0;
        repeat (2) @(posedge text_mem_clk);
        @(negedge text_mem_clk);
        rst = 1'b0;
        check_value("dmem_rvalid", 32'h0, 32'(dmem_rvalid));

        // full words first so partial writes merge into known data
        for (int i = 0; i < 8; i++) begin
            data_idx[i] = DATA_AW'(rand_bits(3) * 8 + i);
            d = rand_bits(32);
            issue(OP_WRITE, ADDR_W'(data_idx[i]), d, 4'hf, waited);
        end
        for (int i = 0; i < 8; i++) begin
            d = rand_bits(32);
            be = 4'(rand_bits(4));
            issue(OP_WRITE, ADDR_W'(data_idx[i]), d, be, waited);
        end
        for (int i = 0; i < 8; i++) begin
            issue(OP_READ, ADDR_W'(data_idx[i]), 32'h0, 4'h0, waited);
        end
        wait_returns();
        report_test(1, "data memory");

        // text writes, ready held low for idle and both write cycles
        for (int i = 0; i < 8; i++) begin
            t_widx[i] = (TEXT_AW-2)'(rand_bits(10) * 8 + i);
            lane = 2'(rand_bits(2));
            t_lane[i] = lane;
            be = 4'b1000 >> lane;
            d = rand_bits(32);
            issue(OP_WRITE, {REG_TEXT, 13'h0, t_widx[i]}, d, be, waited);
            checks++;
            assert (waited == 3) else begin
                $display("time %0t text write taken after %0d wait cycles, expected 3",
                         $time, waited);
                errors++;
            end
        end
        for (int i = 0; i < 8; i++) begin
            text_scan_addr = {t_widx[i], t_lane[i]};
            @(posedge text_mem_clk);
            @(negedge text_mem_clk);
            check_value("text_scan_char", 32'(model_text[{t_widx[i], t_lane[i]}]),
                        32'(text_scan_char));
        end
        report_test(2, "text writes");

        for (int i = 0; i < 8; i++) begin
            ld_idx[i] = LOADER_AW'(rand_bits(10) * 8 + i);
            d = rand_bits(32);
            issue(OP_WRITE, {REG_LOADER, 13'h0, ld_idx[i]}, d, 4'hf, waited);
        end
        for (int i = 0; i < 8; i++) begin
            issue(OP_READ, {REG_LOADER, 13'h0, ld_idx[i]}, 32'h0, 4'h0, waited);
        end
        wait_returns();
        // outside loader port owns port a again
        for (int i = 0; i < 8; i++) begin
            loader_addr = ld_idx[i];
            @(posedge text_mem_clk);
            @(negedge text_mem_clk);
            check_value("loader_rdata", model_loader[ld_idx[i]], loader_rdata);
        end
        report_test(3, "loader ram");

        // fetch from region f, then from data memory
        for (int i = 0; i < 8; i++) begin
            instr_addr = {REG_LOADER, 13'h0, ld_idx[i]};
            @(posedge text_mem_clk);
            @(negedge text_mem_clk);
            check_value("instr_rdata", exp_read(instr_addr), instr_rdata);
            instr_addr = ADDR_W'(data_idx[i]);
            @(posedge text_mem_clk);
            @(negedge text_mem_clk);
            check_value("instr_rdata", exp_read(instr_addr), instr_rdata);
        end
        report_test(4, "instruction fetch");

        // stub writes alias the low bits of live loader and data words
        for (int i = 0; i < 8; i++) begin
            stub = i[0] ? REG_KBD : REG_TIMER;
            a = {stub, 26'(rand_bits(26))};
            issue(OP_READ, a, 32'h0, 4'h0, waited);
            d = rand_bits(32);
            issue(OP_WRITE, {stub, 13'h0, ld_idx[i]}, d, 4'hf, waited);
            d = rand_bits(32);
            issue(OP_WRITE, {stub, 16'h0, data_idx[i]}, d, 4'hf, waited);
        end
        for (int i = 0; i < 8; i++) begin
            issue(OP_READ, ADDR_W'(data_idx[i]), 32'h0, 4'h0, waited);
            issue(OP_READ, {REG_LOADER, 13'h0, ld_idx[i]}, 32'h0, 4'h0, waited);
        end
        wait_returns();
        report_test(5, "stubs");

        // no idle cycles between requests
        for (int i = 0; i < 16; i++) begin
            lane = 2'(rand_bits(1));
            be = 4'(rand_bits(3));
            a = lane[0] ? {REG_LOADER, 13'h0, ld_idx[be[2:0]]} : ADDR_W'(data_idx[be[2:0]]);
            issue(OP_READ, a, 32'h0, 4'h0, waited);
        end
        wait_returns();
        report_test(6, "back to back mix");

        $display("all tests done with %0d checks and %0d errors", checks, errors);
        if (errors == 0) begin
            $display("TEST PASS");
        end else begin
            $display("TEST FAIL");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: list.f
+incdir+verification
design/mem_map_pkg.sv
design/bus_pkg.sv
design/region_decoder.sv
design/text_write_seq.sv
design/data_ram.sv
design/loader_ram.sv
design/text_ram.sv
design/cpu_mem_interface.sv
verification/tb_cpu_mem_interface.sv
